// File: source/cam_cfg_pkg.sv
package cam_cfg_pkg;

   typedef logic [15:0] reg_addr_t;   // sensor register address
   typedef logic [7:0]  reg_data_t;   // sensor register value
   typedef logic [4:0]  script_idx_t; // script entry number

   localparam logic [6:0] SENSOR_ADDR = 7'h36;   // 7-bit form of 0x6c
   localparam logic [7:0] SENSOR_WR   = {SENSOR_ADDR, 1'b0};
   localparam logic [7:0] SENSOR_RD   = {SENSOR_ADDR, 1'b1};

   localparam reg_addr_t ID_REG     = 16'h300B; // chip id byte
   localparam reg_data_t ID_VALUE   = 8'h88;
   localparam logic [7:0] DELAY_MARK = 8'hAA;   // tag of a delay entry

   localparam int SCRIPT_LEN = 24;

   // one script line, tag byte on top
   typedef struct packed {
      logic [7:0] tag;  // SENSOR_WR or DELAY_MARK
      reg_addr_t  addr;
      reg_data_t  data; // delay units for a delay entry
   } script_entry_t;

   // transactions the sequencer can ask for
   typedef enum logic [1:0] {
      OP_WRITE_REG,     // addr, reg hi, reg lo, data
      OP_WRITE_PTR,     // addr, reg hi, reg lo
      OP_READ           // read addr, one byte
   } xfer_op_t;

   // single bus operations of the bit layer
   typedef enum logic [1:0] {
      BIT_START,
      BIT_STOP,
      BIT_WRITE,
      BIT_READ
   } bit_cmd_t;

endpackage

// File: source/cfg_script_rom.sv
`timescale 1ns/1ps

module cfg_script_rom (
   input  cam_cfg_pkg::script_idx_t   rom_idx,
   output cam_cfg_pkg::script_entry_t rom_entry
);

   function automatic cam_cfg_pkg::script_entry_t wr(
      input cam_cfg_pkg::reg_addr_t addr,
      input cam_cfg_pkg::reg_data_t data
   );
      wr = {cam_cfg_pkg::SENSOR_WR, addr, data};
   endfunction

   function automatic cam_cfg_pkg::script_entry_t dly(input cam_cfg_pkg::reg_data_t units);
      dly = {cam_cfg_pkg::DELAY_MARK, 16'h0000, units};
   endfunction

   always_comb begin
      case (rom_idx)
         5'd0:    rom_entry = wr(16'h0103, 8'h01); // software reset
         5'd1:    rom_entry = wr(16'h0100, 8'h00); // software standby
         5'd2:    rom_entry = dly(8'd10);
         5'd3:    rom_entry = wr(16'h0302, 8'd24); // pll1 multiplier
         5'd4:    rom_entry = wr(16'h0303, 8'h00); // pll1 divm
         5'd5:    rom_entry = wr(16'h0304, 8'h03); // pll1 mipi div
         5'd6:    rom_entry = wr(16'h030e, 8'h00); // pll2 r_divs
         5'd7:    rom_entry = wr(16'h030f, 8'h04); // pll2 r_divsp
         5'd8:    rom_entry = wr(16'h0312, 8'h01); // pll2 pre div
         5'd9:    rom_entry = wr(16'h031e, 8'h0c);
         5'd10:   rom_entry = wr(16'h3015, 8'h01); // clock div
         5'd11:   rom_entry = wr(16'h3018, 8'h72); // mipi 4 lane
         5'd12:   rom_entry = wr(16'h3808, 8'h02); // x size hi, 640
         5'd13:   rom_entry = wr(16'h3809, 8'h80); // x size lo
         5'd14:   rom_entry = wr(16'h380a, 8'h01); // y size hi, 480
         5'd15:   rom_entry = wr(16'h380b, 8'hE0); // y size lo
         5'd16:   rom_entry = wr(16'h3503, 8'h00); // no gain/exposure delay
         5'd17:   rom_entry = wr(16'h3508, 8'h03); // analog gain hi
         5'd18:   rom_entry = wr(16'h3509, 8'h00); // analog gain lo
         5'd19:   rom_entry = wr(16'h5018, 8'h19); // red wb gain
         5'd20:   rom_entry = wr(16'h501a, 8'h10); // green wb gain
         5'd21:   rom_entry = wr(16'h501c, 8'h17); // blue wb gain
         5'd22:   rom_entry = dly(8'd10);
         5'd23:   rom_entry = wr(16'h0100, 8'h01); // wake up, streaming
         default: rom_entry = dly(8'd0);           // past the end
      endcase
   end

endmodule

// File: source/i2c_bit_phy.sv
`timescale 1ns/1ps

module i2c_bit_phy (
   input  logic                  CLK_400K,
   input  logic                  RESET_N,
   input  logic                  bit_req,
   input  cam_cfg_pkg::bit_cmd_t bit_cmd,
   input  logic                  bit_wdata,
   output logic                  bit_ack,
   output logic                  bit_rdata,
   inout  wire                   i2c_scl,
   inout  wire                   i2c_sda
);

   logic       busy;
   logic [1:0] quarter; // next quarter to put on the bus
   logic       step;
   logic       scl_hi;  // 1 releases the line
   logic       sda_hi;
   logic       nxt_scl;
   logic       nxt_sda;

   assign step = busy | (bit_req & ~bit_ack);

   // line levels per command and quarter
   always_comb begin
      nxt_scl = 1'b0;
      nxt_sda = 1'b1;
      case (bit_cmd)
         cam_cfg_pkg::BIT_START: begin
            nxt_scl = (quarter != 2'd3);
            nxt_sda = (quarter < 2'd2);  // sda falls with scl high
         end
         cam_cfg_pkg::BIT_STOP: begin
            nxt_scl = (quarter != 2'd0);
            nxt_sda = (quarter == 2'd3); // sda rises with scl high
         end
         cam_cfg_pkg::BIT_WRITE: begin
            nxt_scl = (quarter == 2'd1) || (quarter == 2'd2);
            nxt_sda = bit_wdata;
         end
         default: begin
            nxt_scl = (quarter == 2'd1) || (quarter == 2'd2);
            nxt_sda = 1'b1;              // let the slave drive
         end
      endcase
   end

   always_ff @(posedge CLK_400K) begin
      if (!RESET_N) begin
         busy    <= 1'b0;
         quarter <= 2'd0;
         bit_ack <= 1'b0;
         scl_hi  <= 1'b1;
         sda_hi  <= 1'b1;
      end else begin
         if (step) begin
            scl_hi  <= nxt_scl;
            sda_hi  <= nxt_sda;
            quarter <= quarter + 2'd1;     // wraps to 0 after q3
            busy    <= (quarter != 2'd3);
         end
         if (busy && quarter == 2'd3)
            bit_ack <= 1'b1;
         else if (!bit_req)
            bit_ack <= 1'b0;
      end
   end

   // sda seen during the third quarter
   always_ff @(posedge CLK_400K) begin
      if (busy && quarter == 2'd3)
         bit_rdata <= i2c_sda;
   end

   // open drain, never drive high
   assign i2c_scl = scl_hi ? 1'bz : 1'b0;
   assign i2c_sda = sda_hi ? 1'bz : 1'b0;

endmodule

// File: source/i2c_xfer_ctrl.sv
`timescale 1ns/1ps

module i2c_xfer_ctrl (
   input  logic                   CLK_400K,
   input  logic                   RESET_N,
   input  logic                   xfer_req,
   input  cam_cfg_pkg::xfer_op_t  xfer_op,
   input  cam_cfg_pkg::reg_addr_t xfer_reg,
   input  cam_cfg_pkg::reg_data_t xfer_data,
   output logic                   xfer_ack,
   output logic                   xfer_nack,
   output cam_cfg_pkg::reg_data_t xfer_rdata,
   output logic                   bit_req,
   output cam_cfg_pkg::bit_cmd_t  bit_cmd,
   output logic                   bit_wdata,
   input  logic                   bit_ack,
   input  logic                   bit_rdata
);

   typedef enum logic [2:0] {X_IDLE, X_START, X_BYTE, X_ACK, X_STOP, X_DONE} xstate_t;

   xstate_t    state;
   logic [7:0] sh;        // tx byte out, rx byte in
   logic [2:0] bit_cnt;
   logic [1:0] byte_cnt;
   logic [1:0] last_idx;
   logic [1:0] load_idx;
   logic [7:0] load_byte;
   logic       rd_byte;   // data phase of a read
   logic       bit_done;

   assign bit_done   = bit_req & bit_ack;
   assign rd_byte    = (xfer_op == cam_cfg_pkg::OP_READ) && (byte_cnt == 2'd1);
   assign last_idx   = (xfer_op == cam_cfg_pkg::OP_WRITE_REG) ? 2'd3 :
                       (xfer_op == cam_cfg_pkg::OP_WRITE_PTR) ? 2'd2 : 2'd1;
   assign load_idx   = (state == X_IDLE) ? 2'd0 : byte_cnt + 2'd1;
   assign xfer_rdata = sh;

   always_comb begin
      case (load_idx)
         2'd0:    load_byte = (xfer_op == cam_cfg_pkg::OP_READ) ? cam_cfg_pkg::SENSOR_RD
                                                               : cam_cfg_pkg::SENSOR_WR;
         2'd1:    load_byte = xfer_reg[15:8];
         2'd2:    load_byte = xfer_reg[7:0];
         default: load_byte = xfer_data;
      endcase
   end

   always_comb begin
      bit_cmd   = cam_cfg_pkg::BIT_READ;
      bit_wdata = 1'b1;
      case (state)
         X_START: bit_cmd = cam_cfg_pkg::BIT_START;
         X_STOP:  bit_cmd = cam_cfg_pkg::BIT_STOP;
         X_BYTE: begin
            bit_cmd   = rd_byte ? cam_cfg_pkg::BIT_READ : cam_cfg_pkg::BIT_WRITE;
            bit_wdata = sh[7];                 // msb first
         end
         X_ACK:   bit_cmd = rd_byte ? cam_cfg_pkg::BIT_WRITE : cam_cfg_pkg::BIT_READ;
         default: bit_cmd = cam_cfg_pkg::BIT_READ;
      endcase
   end

   always_ff @(posedge CLK_400K) begin
      if (!RESET_N) begin
         state     <= X_IDLE;
         bit_req   <= 1'b0;
         bit_cnt   <= 3'd0;
         byte_cnt  <= 2'd0;
         xfer_ack  <= 1'b0;
         xfer_nack <= 1'b0;
      end else begin
         if (state inside {X_START, X_BYTE, X_ACK, X_STOP} && !bit_req && !bit_ack)
            bit_req <= 1'b1;
         else if (bit_done)
            bit_req <= 1'b0;

         case (state)
            X_IDLE: if (xfer_req && !xfer_ack) begin
               xfer_nack <= 1'b0;
               byte_cnt  <= 2'd0;
               state     <= X_START;
            end
            X_START: if (bit_done) begin
               bit_cnt <= 3'd0;
               state   <= X_BYTE;
            end
            X_BYTE: if (bit_done) begin
               bit_cnt <= bit_cnt + 3'd1;
               if (bit_cnt == 3'd7)
                  state <= X_ACK;
            end
            X_ACK: if (bit_done) begin
               if (!rd_byte && bit_rdata) begin
                  xfer_nack <= 1'b1;           // abort on slave nack
                  state     <= X_STOP;
               end else if (byte_cnt == last_idx) begin
                  state <= X_STOP;
               end else begin
                  byte_cnt <= byte_cnt + 2'd1;
                  bit_cnt  <= 3'd0;
                  state    <= X_BYTE;
               end
            end
            X_STOP: if (bit_done) begin
               xfer_ack <= 1'b1;
               state    <= X_DONE;
            end
            default: if (!xfer_req) begin
               xfer_ack <= 1'b0;
               state    <= X_IDLE;
            end
         endcase
      end
   end

   // shift register, loaded per byte
   always_ff @(posedge CLK_400K) begin
      if ((state == X_IDLE && xfer_req && !xfer_ack) ||
          (state == X_ACK && bit_done && byte_cnt != last_idx))
         sh <= load_byte;
      else if (state == X_BYTE && bit_done)
         sh <= {sh[6:0], bit_rdata};
   end

endmodule

// File: source/cam_cfg_sequencer.sv
`timescale 1ns/1ps

module cam_cfg_sequencer #(
   parameter int DELAY_UNIT   = 400,
   parameter int ID_RETRY_GAP = 8
) (
   input  logic                       CLK_400K,
   input  logic                       RESET_N,
   output cam_cfg_pkg::script_idx_t   rom_idx,
   input  cam_cfg_pkg::script_entry_t rom_entry,
   output logic                       xfer_req,
   output cam_cfg_pkg::xfer_op_t      xfer_op,
   output cam_cfg_pkg::reg_addr_t     xfer_reg,
   output cam_cfg_pkg::reg_data_t     xfer_data,
   input  logic                       xfer_ack,
   input  logic                       xfer_nack,
   input  cam_cfg_pkg::reg_data_t     xfer_rdata,
   output logic                       cfg_done,
   output cam_cfg_pkg::reg_data_t     sensor_id
);

   localparam int CNT_MAX = (DELAY_UNIT > ID_RETRY_GAP) ? DELAY_UNIT : ID_RETRY_GAP;
   localparam int CNT_W   = $clog2(CNT_MAX + 1);

   typedef enum logic [3:0] {
      S_INIT, S_PTR, S_READ, S_GAP, S_RUN, S_WRITE, S_DELAY, S_DONE
   } sstate_t;

   sstate_t                state;
   logic [CNT_W-1:0]       cyc_cnt;   // gap and delay unit cycles
   cam_cfg_pkg::reg_data_t unit_cnt;  // delay units elapsed
   logic                   xfer_done;
   logic                   last_entry;

   assign xfer_done  = xfer_req & xfer_ack;
   assign last_entry = (rom_idx == 5'(cam_cfg_pkg::SCRIPT_LEN - 1));

   always_comb begin
      xfer_op   = cam_cfg_pkg::OP_WRITE_REG;
      xfer_reg  = rom_entry.addr;
      xfer_data = rom_entry.data;
      if (state == S_PTR) begin
         xfer_op  = cam_cfg_pkg::OP_WRITE_PTR;
         xfer_reg = cam_cfg_pkg::ID_REG;
      end else if (state == S_READ) begin
         xfer_op  = cam_cfg_pkg::OP_READ;
         xfer_reg = cam_cfg_pkg::ID_REG;
      end
   end

   always_ff @(posedge CLK_400K) begin
      if (!RESET_N) begin
         state     <= S_INIT;
         xfer_req  <= 1'b0;
         rom_idx   <= '0;
         cyc_cnt   <= '0;
         unit_cnt  <= '0;
         cfg_done  <= 1'b0;
         sensor_id <= '0;
      end else begin
         if (state inside {S_PTR, S_READ, S_WRITE} && !xfer_req && !xfer_ack)
            xfer_req <= 1'b1;
         else if (xfer_done)
            xfer_req <= 1'b0;

         case (state)
            S_INIT: state <= S_PTR;       // quiet first cycle
            S_PTR: if (xfer_done) begin
               cyc_cnt <= '0;
               state   <= xfer_nack ? S_GAP : S_READ;
            end
            S_READ: if (xfer_done) begin
               cyc_cnt <= '0;
               if (!xfer_nack)
                  sensor_id <= xfer_rdata;
               if (!xfer_nack && xfer_rdata == cam_cfg_pkg::ID_VALUE)
                  state <= S_RUN;
               else
                  state <= S_GAP;         // probe again
            end
            S_GAP: begin
               cyc_cnt <= cyc_cnt + 1'b1;
               if (cyc_cnt == CNT_W'(ID_RETRY_GAP - 1))
                  state <= S_PTR;
            end
            S_RUN: begin
               cyc_cnt  <= '0;
               unit_cnt <= '0;
               state    <= (rom_entry.tag == cam_cfg_pkg::DELAY_MARK) ? S_DELAY : S_WRITE;
            end
            S_WRITE: if (xfer_done) begin
               if (xfer_nack) begin
                  state <= S_RUN;         // same entry again
               end else if (last_entry) begin
                  cfg_done <= 1'b1;
                  state    <= S_DONE;
               end else begin
                  rom_idx <= rom_idx + 1'b1;
                  state   <= S_RUN;
               end
            end
            S_DELAY: begin
               if (unit_cnt == rom_entry.data) begin
                  if (last_entry) begin
                     cfg_done <= 1'b1;
                     state    <= S_DONE;
                  end else begin
                     rom_idx <= rom_idx + 1'b1;
                     state   <= S_RUN;
                  end
               end else if (cyc_cnt == CNT_W'(DELAY_UNIT - 1)) begin
                  cyc_cnt  <= '0;
                  unit_cnt <= unit_cnt + 1'b1;
               end else begin
                  cyc_cnt <= cyc_cnt + 1'b1;
               end
            end
            default: state <= S_DONE;     // script finished, stay here
         endcase
      end
   end

endmodule

// File: source/cam_cfg_top.sv
`timescale 1ns/1ps

module cam_cfg_top #(
   parameter int DELAY_UNIT   = 400, // clk cycles per delay unit
   parameter int ID_RETRY_GAP = 8
) (
   input  logic                   CLK_400K,
   input  logic                   RESET_N,
   inout  wire                    i2c_scl,
   inout  wire                    i2c_sda,
   output logic                   cfg_done,
   output cam_cfg_pkg::reg_data_t sensor_id
);

   cam_cfg_pkg::script_idx_t   rom_idx;
   cam_cfg_pkg::script_entry_t rom_entry;

   logic                   xfer_req;
   cam_cfg_pkg::xfer_op_t  xfer_op;
   cam_cfg_pkg::reg_addr_t xfer_reg;
   cam_cfg_pkg::reg_data_t xfer_data;
   logic                   xfer_ack;
   logic                   xfer_nack;
   cam_cfg_pkg::reg_data_t xfer_rdata;

   logic                  bit_req;
   cam_cfg_pkg::bit_cmd_t bit_cmd;
   logic                  bit_wdata;
   logic                  bit_ack;
   logic                  bit_rdata;

   cam_cfg_sequencer #(
      .DELAY_UNIT   (DELAY_UNIT),
      .ID_RETRY_GAP (ID_RETRY_GAP)
   ) i_seq (
      .CLK_400K, .RESET_N, .rom_idx, .rom_entry,
      .xfer_req, .xfer_op, .xfer_reg, .xfer_data,
      .xfer_ack, .xfer_nack, .xfer_rdata, .cfg_done, .sensor_id
   );

   cfg_script_rom i_rom (.rom_idx, .rom_entry);

   i2c_xfer_ctrl i_xfer (
      .CLK_400K, .RESET_N, .xfer_req, .xfer_op, .xfer_reg, .xfer_data,
      .xfer_ack, .xfer_nack, .xfer_rdata,
      .bit_req, .bit_cmd, .bit_wdata, .bit_ack, .bit_rdata
   );

   i2c_bit_phy i_phy (
      .CLK_400K, .RESET_N, .bit_req, .bit_cmd, .bit_wdata,
      .bit_ack, .bit_rdata, .i2c_scl, .i2c_sda
   );

endmodule

// File: bench/sensor_i2c_model.sv
`timescale 1ns/1ps

module sensor_i2c_model (
   input  wire                    scl,
   inout  wire                    sda,
   input  cam_cfg_pkg::reg_data_t id_tab [2],
   input  int                     nack_at
);

   cam_cfg_pkg::reg_addr_t rec_addr [64];
   cam_cfg_pkg::reg_data_t rec_data [64];
   time                    rec_time [64];
   int                     rec_reads [64]; // id reads done before this write
   int                     rec_cnt   = 0;
   int                     read_cnt  = 0;
   int                     start_cnt = 0;
   logic                   nack_done = 1'b0;

   logic                   sda_low = 1'b0;
   logic                   scl_q   = 1'b1;
   logic                   sda_q   = 1'b1;
   logic                   active  = 1'b0;
   logic                   tx      = 1'b0; // slave sends the id byte
   logic                   in_ack  = 1'b0;
   logic                   acked   = 1'b0;
   int                     bit_n   = 0;
   int                     byte_n  = 0;
   logic [7:0]             sh;
   logic [7:0]             tx_sh;
   cam_cfg_pkg::reg_addr_t cur_reg;
   cam_cfg_pkg::reg_data_t cur_data;

   assign sda = sda_low ? 1'b0 : 1'bz;

   always @(scl or sda) begin
      if (scl === 1'b1 && scl_q === 1'b1 && sda_q === 1'b1 && sda === 1'b0) begin
         active  = 1'b1;     // start condition
         tx      = 1'b0;
         in_ack  = 1'b0;
         bit_n   = 0;
         byte_n  = 0;
         sda_low = 1'b0;
         start_cnt++;
      end else if (scl === 1'b1 && scl_q === 1'b1 && sda_q === 1'b0 && sda === 1'b1) begin
         if (active && !tx && byte_n == 4) begin // full register write
            rec_addr[rec_cnt]  = cur_reg;
            rec_data[rec_cnt]  = cur_data;
            rec_time[rec_cnt]  = $time;
            rec_reads[rec_cnt] = read_cnt;
            rec_cnt++;
         end
         active  = 1'b0;
         tx      = 1'b0;
         sda_low = 1'b0;
      end else if (active && scl_q !== 1'b1 && scl === 1'b1) begin
         if (!in_ack && bit_n < 8) begin
            sh = {sh[6:0], (sda === 1'b1)};
            bit_n++;
         end
      end else if (active && scl_q === 1'b1 && scl !== 1'b1) begin
         if (in_ack) begin   // end of the ack slot
            in_ack  = 1'b0;
            sda_low = 1'b0;
            bit_n   = 0;
            byte_n++;
            if (!tx && !acked)
               active = 1'b0;
            else if (!tx && byte_n == 1 && sh[0]) begin
               tx      = 1'b1;
               sda_low = !tx_sh[7];
            end
         end else if (bit_n == 8) begin
            in_ack = 1'b1;
            if (tx) begin
               sda_low = 1'b0;   // master nacks the read byte
            end else begin
               acked = 1'b1;
               case (byte_n)
                  0: begin
                     acked = (sh[7:1] == cam_cfg_pkg::SENSOR_ADDR);
                     if (acked && sh[0]) begin
                        tx_sh = id_tab[(read_cnt < 2) ? read_cnt : 1];
                        read_cnt++;
                     end
                  end
                  1: cur_reg[15:8] = sh;
                  2: cur_reg[7:0]  = sh;
                  default: begin
                     cur_data = sh;
                     if (rec_cnt == nack_at && !nack_done) begin
                        acked     = 1'b0; // refuse this write once
                        nack_done = 1'b1;
                     end
                  end
               endcase
               sda_low = acked;
            end
         end else if (tx && byte_n == 1) begin
            sda_low = !tx_sh[7 - bit_n];
         end
      end
      scl_q = scl;
      sda_q = sda;
   end

endmodule

// File: bench/cam_cfg_chk.sv
`timescale 1ns/1ps

module cam_cfg_chk (
   input logic CLK_400K,
   input logic RESET_N,
   input logic xfer_req,
   input logic xfer_ack,
   input logic bit_req,
   input logic bit_ack
);

   int fail_cnt = 0;   // assertion failures so far

   ack_needs_req: assert property (@(posedge CLK_400K) disable iff (!RESET_N)
      $rose(xfer_ack) |-> xfer_req)
      else begin
         $error("xfer_ack rose while xfer_req was low");
         fail_cnt++;
      end

   xfer_req_held: assert property (@(posedge CLK_400K) disable iff (!RESET_N)
      $fell(xfer_req) |-> $past(xfer_ack))
      else begin
         $error("xfer_req dropped before xfer_ack");
         fail_cnt++;
      end

   bit_req_held: assert property (@(posedge CLK_400K) disable iff (!RESET_N)
      $fell(bit_req) |-> $past(bit_ack))
      else begin
         $error("bit_req dropped before bit_ack");
         fail_cnt++;
      end

endmodule

bind i2c_xfer_ctrl cam_cfg_chk i_chk (.*);

// File: bench/tb_cam_cfg.sv
`timescale 1ns/1ps

module tb_cam_cfg;

   localparam int UNIT        = 16;
   localparam int N_WR        = 22;  // script writes, delays left out
   localparam int DELAY_UNITS = 20;
   localparam int WR_BITS     = 38;  // start, four bytes with ack, stop
   localparam int MIN_WR      = WR_BITS * 4; // four cycles per bus operation
   // about 40 bits of 8 cycles per entry, plus probes and the retry
   localparam int LIMIT = (cam_cfg_pkg::SCRIPT_LEN + 4) * 320 + DELAY_UNITS * UNIT;

   localparam cam_cfg_pkg::reg_addr_t EXP_ADDR [N_WR] = '{
      16'h0103, 16'h0100, 16'h0302, 16'h0303, 16'h0304, 16'h030e, 16'h030f, 16'h0312,
      16'h031e, 16'h3015, 16'h3018, 16'h3808, 16'h3809, 16'h380a, 16'h380b, 16'h3503,
      16'h3508, 16'h3509, 16'h5018, 16'h501a, 16'h501c, 16'h0100};
   localparam cam_cfg_pkg::reg_data_t EXP_DATA [N_WR] = '{
      8'h01, 8'h00, 8'd24, 8'h00, 8'h03, 8'h00, 8'h04, 8'h01,
      8'h0c, 8'h01, 8'h72, 8'h02, 8'h80, 8'h01, 8'hE0, 8'h00,
      8'h03, 8'h00, 8'h19, 8'h10, 8'h17, 8'h01};
   // delay units that precede each write
   localparam int EXP_GAP [N_WR] = '{
      0, 0, 10, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 10};
   localparam cam_cfg_pkg::reg_data_t ID_TAB [2] = '{8'h55, cam_cfg_pkg::ID_VALUE};

   logic                   CLK_400K;
   logic                   RESET_N;
   wire                    i2c_scl;
   wire                    i2c_sda;
   logic                   cfg_done;
   cam_cfg_pkg::reg_data_t sensor_id;
   cam_cfg_pkg::reg_data_t id_tab [2];
   int                     nack_at;
   int                     cyc = 0;

   pullup (i2c_scl);
   pullup (i2c_sda);

   cam_cfg_top #(.DELAY_UNIT(UNIT)) i_dut (
      .CLK_400K, .RESET_N, .i2c_scl, .i2c_sda, .cfg_done, .sensor_id
   );

   sensor_i2c_model i_model (.scl(i2c_scl), .sda(i2c_sda), .id_tab, .nack_at);

   function automatic logic [31:0] xorshift32(input logic [31:0] s);
      logic [31:0] x;
      x = s;
      x = x ^ (x << 13);
      x = x ^ (x >> 17);
      x = x ^ (x << 5);
      return x;
   endfunction

   task automatic report_error(input string msg);
      $display("[ERROR] time %0t: %s", $time, msg);
      $display("RESULT: FAIL");
      $fatal(1, "stopped at first error");
   endtask

   task automatic report_failure(input string msg);
      $display("%s", msg);
      $display("RESULT: FAIL");
      $fatal(1, "run aborted");
   endtask

   task automatic check_reg(input cam_cfg_pkg::reg_addr_t got, input cam_cfg_pkg::reg_addr_t exp,
                            input string what);
      if (got !== exp)
         report_error($sformatf("%s: register 0x%04h, expected 0x%04h", what, got, exp));
   endtask

   task automatic check_data(input cam_cfg_pkg::reg_data_t got, input cam_cfg_pkg::reg_data_t exp,
                             input string what);
      if (got !== exp)
         report_error($sformatf("%s: data 0x%02h, expected 0x%02h", what, got, exp));
   endtask

   task automatic check_id(input cam_cfg_pkg::reg_data_t got, input cam_cfg_pkg::reg_data_t exp);
      if (got !== exp)
         report_error($sformatf("sensor_id 0x%02h, expected 0x%02h", got, exp));
   endtask

   task automatic check_bit(input logic got, input logic exp, input string what);
      if (got !== exp)
         report_error($sformatf("%s: %b, expected %b", what, got, exp));
   endtask

   task automatic check_idle(input string when);
      check_bit(cfg_done, 1'b0, {"cfg_done ", when});
      check_bit(i2c_scl, 1'b1, {"scl ", when});
      check_bit(i2c_sda, 1'b1, {"sda ", when});
      check_id(sensor_id, 8'h00);
   endtask

   initial begin
      CLK_400K = 1'b0;
      forever #5 CLK_400K = ~CLK_400K;
   end

   always @(posedge CLK_400K) begin
      cyc <= cyc + 1;
      if (cyc >= LIMIT)
         report_failure($sformatf("timeout: configuration not finished after %0d cycles", LIMIT));
   end

   initial begin
      int  i;
      int  starts;
      time gap_ns;
      RESET_N = 1'b0;
      id_tab  = ID_TAB;
      nack_at = int'(xorshift32(32'd50606) % N_WR); // write refused once
      repeat (10) begin
         @(negedge CLK_400K);
         check_idle("in reset");
      end
      RESET_N = 1'b1;
      @(negedge CLK_400K);
      check_idle("after reset");

      for (i = 0; i < N_WR; i++) begin
         while (i_model.rec_cnt <= i) begin
            check_bit(cfg_done, 1'b0, "cfg_done before last write");
            @(negedge CLK_400K);
         end
         check_reg(i_model.rec_addr[i], EXP_ADDR[i], $sformatf("write %0d", i));
         check_data(i_model.rec_data[i], EXP_DATA[i], $sformatf("write %0d", i));
         if (i > 0) begin
            // a whole write transaction plus the delay lies between two writes
            gap_ns = i_model.rec_time[i] - i_model.rec_time[i-1];
            if (gap_ns < (EXP_GAP[i] * UNIT + MIN_WR) * 10)
               report_error($sformatf("write %0d only %0t after previous", i, gap_ns));
         end
      end
      if (i_model.rec_reads[0] != 2)
         report_error($sformatf("first write after %0d id reads, expected 2",
                                i_model.rec_reads[0]));
      check_bit(i_model.nack_done, 1'b1, "nack injected");

      while (!cfg_done)
         @(negedge CLK_400K);
      if (i_model.rec_cnt != N_WR)
         report_error($sformatf("%0d writes at cfg_done, expected %0d", i_model.rec_cnt, N_WR));
      starts = i_model.start_cnt;
      repeat (200) @(negedge CLK_400K);
      if (i_model.start_cnt != starts)
         report_error("bus activity after cfg_done");
      check_bit(i2c_scl, 1'b1, "scl after done");
      check_bit(i2c_sda, 1'b1, "sda after done");
      check_id(sensor_id, cam_cfg_pkg::ID_VALUE);

      if (i_dut.i_xfer.i_chk.fail_cnt != 0) begin
         report_failure("handshake assertion failed during the run");
      end else begin
         $display("RESULT: PASS");
         $finish;
      end
   end

endmodule

// File: list.f
source/cam_cfg_pkg.sv
source/cfg_script_rom.sv
source/i2c_bit_phy.sv
source/i2c_xfer_ctrl.sv
source/cam_cfg_sequencer.sv
source/cam_cfg_top.sv
bench/sensor_i2c_model.sv
bench/cam_cfg_chk.sv
bench/tb_cam_cfg.sv

// File: Makefile
TOP := tb_cam_cfg

.PHONY: lint sim clean

lint:
	verilator --lint-only -Wall --timing --top-module $(TOP) -f list.f

sim:
	verilator --binary --timing --assert -j 0 --top-module $(TOP) -f list.f -o $(TOP)
	./obj_dir/$(TOP) | tee /dev/stderr | grep -q "RESULT: PASS"

clean:
	rm -rf obj_dir
